// File: tb.f
+incdir+dv
common/dot_pkg.sv
group_mac/group_mac.sv
group_add/group_add.sv
source/dot_accumulate.sv
source/dot_product_unit.sv
dv/dot_product_unit_tb.sv

// File: dv/dot_vectors.svh
// one row of the directed table.
typedef struct packed {
    dot_pkg::group_t data;    // activations, lane 0 in the low bits.
    dot_pkg::group_t weight;  // weights, same lane order.
    logic            last;    // closes the dot product.
    logic [7:0]      gap;     // idle cycles after the beat.
} vec_row_t;

localparam int fixed_rows  = 14;
localparam int random_rows = 24;

// columns: data (lane 3 .. lane 0), weight (lane 3 .. lane 0), last, gap.
// all values in q8.8, so 16'h0100 is 1.0.
localparam vec_row_t fixed_table [fixed_rows] = '{
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // single beat with small positive values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    '{64'h0040_0080_0200_0100, 64'h0010_0300_0080_0100, 1'b1, 8'd10},
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // signed lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    '{64'hff00_0200_fe00_ffff, 64'hff00_0100_0100_0080, 1'b1, 8'd2},   // -1*-1, cancel.
    '{64'h8000_ff80_0001_fffe, 64'h0100_0100_0080_0003, 1'b1, 8'd3},   // rounds toward -inf.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // multi-beat product with idle gaps
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    '{64'h0100_0100_0100_0100, 64'h0200_0100_0080_0040, 1'b0, 8'd3},
    '{64'h0180_fe80_0300_0040, 64'h0100_0200_ff00_0400, 1'b0, 8'd5},
    '{64'h0010_0020_0030_0040, 64'h1000_0800_0400_0200, 1'b1, 8'd4},
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // back-to-back products
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    '{64'h0100_0200_0300_0400, 64'h0100_0100_0100_0100, 1'b0, 8'd0},
    '{64'h0500_0600_0700_0800, 64'h0080_0080_0080_0080, 1'b1, 8'd0},
    '{64'h0001_0002_0003_0004, 64'h7fff_7fff_7fff_7fff, 1'b1, 8'd0},
    '{64'hff00_ff00_ff00_ff00, 64'h0100_0100_0100_0100, 1'b1, 8'd0},
    '{64'h0080_0080_0080_0080, 64'h0080_0080_0080_0080, 1'b1, 8'd2},
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wrap at 16 bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    '{64'h3000_3000_3000_3000, 64'h0100_0100_0100_0100, 1'b1, 8'd0},   // lane sum wraps.
    '{64'h4000_7fff_7fff_0200, 64'h0200_7fff_7fff_0200, 1'b0, 8'd1},
    '{64'h7000_7000_7000_7000, 64'h0100_0100_0100_0100, 1'b1, 8'd4}    // total wraps.
};

// File: dv/dot_product_unit_tb.sv
module dot_product_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    `include "dot_vectors.svh"

    localparam int clk_period     = 8;
    localparam int reset_cycles   = 5;
    localparam int result_latency = 8;  // drive edge to dn_valid.

    logic           clk;
    logic           reset;
    dot_pkg::beat_t up_beat;
    logic           dn_valid;
    dot_pkg::num_t  dn_data;

    integer          seed;
    int              cycle_cnt = 0;
    int              pulse_cnt = 0;
    int              last_cnt  = 0;
    vec_row_t        rows [$];
    dot_pkg::num_t   exp_data_q [$];   // expected results in order.
    int              exp_cycle_q [$];  // drive cycle of each last beat.

    dot_product_unit dut_i (
        .clk      (clk),
        .reset    (reset),
        .up_beat  (up_beat),
        .dn_valid (dn_valid),
        .dn_data  (dn_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // q8.8 multiply, low fraction bits dropped.
    function automatic dot_pkg::num_t lane_product(input dot_pkg::num_t a, input dot_pkg::num_t b);
        int p;
        p = int'(a) * int'(b);
        return dot_pkg::num_t'(p >>> dot_pkg::fract_width);
    endfunction

    function automatic dot_pkg::num_t beat_sum(input vec_row_t r);
        dot_pkg::num_t s;
        dot_pkg::num_t a;
        dot_pkg::num_t b;
        s = '0;
        for (int i = 0; i < dot_pkg::group_nb; i++) begin
            a = r.data[i*dot_pkg::num_width +: dot_pkg::num_width];
            b = r.weight[i*dot_pkg::num_width +: dot_pkg::num_width];
            s = s + lane_product(a, b);  // wraps at 16 bits.
        end
        return s;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            fail_run($sformatf("Mismatch at %0t: %s is %0h, expected %0h",
                               $time, what, got, expected));
        end
    endtask

    // results are sampled mid-cycle.
    always @(negedge clk) begin
        if (!reset && dn_valid) begin
            if (exp_data_q.size() == 0) begin
                fail_run("dn_valid pulsed while no result was expected");
            end else begin
                check_value(dn_data, exp_data_q.pop_front(), "dn_data");
                check_value(cycle_cnt, exp_cycle_q.pop_front() + result_latency,
                            "dn_valid cycle");
                pulse_cnt++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        vec_row_t      r;
        dot_pkg::num_t model_total;
        logic          model_run;
        int            limit_cycles;

        reset       = 1'b1;
        up_beat     = '0;
        seed        = 6;
        model_total = '0;
        model_run   = 1'b0;

        foreach (fixed_table[i]) begin
            rows.push_back(fixed_table[i]);
        end
        for (int i = 0; i < random_rows; i++) begin
            r.data   = {$random(seed), $random(seed)};
            r.weight = {$random(seed), $random(seed)};
            r.last   = (($random(seed) & 3) == 0);
            r.gap    = 8'($random(seed) & 3);
            if (i == random_rows - 1) begin
                r.last = 1'b1;  // flush the final product.
            end
            rows.push_back(r);
        end

        limit_cycles = rows.size() + 20;
        foreach (rows[i]) begin
            limit_cycles += rows[i].gap;
        end

        fork
            begin
                #(limit_cycles * clk_period);
                $display("watchdog expired before all results came out");
                $display("tests failed");
                $fatal(1, "watchdog");
            end
        join_none

        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;

        foreach (rows[i]) begin
            @(posedge clk);
            #1;
            up_beat.valid  = 1'b1;
            up_beat.last   = rows[i].last;
            up_beat.data   = rows[i].data;
            up_beat.weight = rows[i].weight;

            if (model_run) begin
                model_total = model_total + beat_sum(rows[i]);
            end else begin
                model_total = beat_sum(rows[i]);
            end
            if (rows[i].last) begin
                exp_data_q.push_back(model_total);
                exp_cycle_q.push_back(cycle_cnt);
                last_cnt++;
                model_run = 1'b0;
            end else begin
                model_run = 1'b1;
            end

            for (int g = 0; g < rows[i].gap; g++) begin
                @(posedge clk);
                #1 up_beat = '0;
            end
        end

        @(posedge clk);
        #1 up_beat = '0;

        // the final result is due a fixed latency after the last beat.
        repeat (result_latency + 2) @(posedge clk);

        if (exp_data_q.size() != 0 || pulse_cnt != last_cnt) begin
            fail_run($sformatf("saw %0d results for %0d last beats", pulse_cnt, last_cnt));
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// File: source/dot_product_unit.sv
module dot_product_unit (
    input  logic           clk,
    input  logic           reset,
    input  dot_pkg::beat_t up_beat,
    output logic           dn_valid,
    output dot_pkg::num_t  dn_data
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal wiring
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dot_pkg::group_t mac_data;  // rescaled lane products.
    dot_pkg::tag_t   mac_tag;   // strobes beside mac_data.
    dot_pkg::num_t   beat_sum;  // adder tree output.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // multiply each lane pair.
    group_mac group_mac_i (
        .clk      (clk),
        .reset    (reset),
        .up_beat  (up_beat),
        .mac_data (mac_data),
        .mac_tag  (mac_tag)
    );

    // sum the four lanes.
    group_add group_add_i (
        .clk     (clk),
        .up_data (mac_data),
        .dn_data (beat_sum)
    );

    // total the beats of one dot product.
    dot_accumulate dot_accumulate_i (
        .clk      (clk),
        .reset    (reset),
        .mac_tag  (mac_tag),
        .sum      (beat_sum),
        .dn_valid (dn_valid),
        .dn_data  (dn_data)
    );

endmodule

// File: source/dot_accumulate.sv
module dot_accumulate (
    input  logic          clk,
    input  logic          reset,
    input  dot_pkg::tag_t mac_tag,
    input  dot_pkg::num_t sum,
    output logic          dn_valid,
    output dot_pkg::num_t dn_data
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // strobe alignment
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dot_pkg::tag_t tag_pipe [dot_pkg::add_latency];  // follows the adder tree.
    dot_pkg::tag_t tag_al;                           // lined up with sum.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < dot_pkg::add_latency; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            tag_pipe[0] <= mac_tag;
            for (int i = 1; i < dot_pkg::add_latency; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign tag_al = tag_pipe[dot_pkg::add_latency-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // accumulator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dot_pkg::acc_state_t state;
    dot_pkg::acc_state_t state_next;
    dot_pkg::num_t       total;       // running sum of the beats.
    dot_pkg::num_t       total_next;

    // idle starts a fresh total from the incoming beat sum.
    always_comb begin
        if (state == dot_pkg::acc_idle) begin
            total_next = sum;
        end else begin
            total_next = total + sum;  // wraps at the number width.
        end
    end

    always_comb begin
        state_next = state;
        if (tag_al.valid) begin
            if (tag_al.last) begin
                state_next = dot_pkg::acc_idle;
            end else begin
                state_next = dot_pkg::acc_run;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= dot_pkg::acc_idle;
            dn_valid <= 1'b0;
        end else begin
            state    <= state_next;
            dn_valid <= tag_al.valid && tag_al.last;  // one-cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        if (tag_al.valid) begin
            total <= total_next;
        end
        if (tag_al.valid && tag_al.last) begin
            dn_data <= total_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // back-to-back results only when two last beats entered back to back.
    pulse_pairs_a : assert property (
        @(posedge clk) disable iff (reset)
        dn_valid && $past(dn_valid)
        |-> $past(mac_tag.valid && mac_tag.last, dot_pkg::add_latency + 1) &&
            $past(mac_tag.valid && mac_tag.last, dot_pkg::add_latency + 2)
    ) else $error("dot_accumulate: dn_valid held without two last beats");

endmodule

// File: group_add/group_add.sv
module group_add (
    input  logic            clk,
    input  dot_pkg::group_t up_data,
    output dot_pkg::num_t   dn_data
);

    // pick one lane out of a group.
    function automatic dot_pkg::num_t lane(input dot_pkg::group_t g, input int idx);
        return g[idx*dot_pkg::num_width +: dot_pkg::num_width];
    endfunction

    // two-input add that wraps at the number width.
    function automatic dot_pkg::num_t add_wrap(input dot_pkg::num_t a, input dot_pkg::num_t b);
        return a + b;
    endfunction

    // reference sum over all lanes.
    function automatic dot_pkg::num_t sum_lanes(input dot_pkg::group_t g);
        dot_pkg::num_t acc;
        acc = '0;
        for (int i = 0; i < dot_pkg::group_nb; i++) begin
            acc = add_wrap(acc, lane(g, i));
        end
        return acc;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // adder tree, fixed at four lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dot_pkg::group_t up_data_r;        // input register.
    dot_pkg::num_t   pair_sum  [2];    // lanes 0+1 and 2+3.
    dot_pkg::num_t   pair_hold [2];    // balance stage.
    dot_pkg::num_t   total;            // final add.

    always_ff @(posedge clk) begin
        up_data_r <= up_data;
    end

    always_ff @(posedge clk) begin
        pair_sum[0] <= add_wrap(lane(up_data_r, 0), lane(up_data_r, 1));
        pair_sum[1] <= add_wrap(lane(up_data_r, 2), lane(up_data_r, 3));
    end

    always_ff @(posedge clk) begin
        pair_hold <= pair_sum;
    end

    always_ff @(posedge clk) begin
        total   <= add_wrap(pair_hold[0], pair_hold[1]);
        dn_data <= total;  // five stages from up_data.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // counts edges until the pipeline history is filled.
    logic [2:0] warm_cnt = '0;

    always_ff @(posedge clk) begin
        if (warm_cnt != 3'(dot_pkg::add_latency)) begin
            warm_cnt <= warm_cnt + 3'd1;
        end
    end

    // output matches the wrapped lane sum from one pipeline depth ago.
    sum_matches_a : assert property (
        @(posedge clk)
        (warm_cnt == 3'(dot_pkg::add_latency)) &&
        !$isunknown($past(up_data, dot_pkg::add_latency))
        |-> dn_data == sum_lanes($past(up_data, dot_pkg::add_latency))
    ) else $error("group_add: dn_data is not the sum of the lanes");

endmodule

// File: group_mac/group_mac.sv
module group_mac (
    input  logic            clk,
    input  logic            reset,
    input  dot_pkg::beat_t  up_beat,
    output dot_pkg::group_t mac_data,
    output dot_pkg::tag_t   mac_tag
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage one registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dot_pkg::tag_t    tag_r;     // strobes of the held beat.
    dot_pkg::group_t  data_r;    // held activations.
    dot_pkg::group_t  weight_r;  // held weights.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage two arithmetic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dot_pkg::num_t     data_lane   [dot_pkg::group_nb];
    dot_pkg::num_t     weight_lane [dot_pkg::group_nb];
    dot_pkg::product_t product     [dot_pkg::group_nb];
    dot_pkg::group_t   scaled;      // rescaled products, packed.

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_r <= '0;
        end else begin
            tag_r.valid <= up_beat.valid;
            tag_r.last  <= up_beat.last;
        end
    end

    always_ff @(posedge clk) begin
        data_r   <= up_beat.data;
        weight_r <= up_beat.weight;
    end

    // split the held groups into lanes.
    always_comb begin
        for (int i = 0; i < dot_pkg::group_nb; i++) begin
            data_lane[i]   = data_r[i*dot_pkg::num_width +: dot_pkg::num_width];
            weight_lane[i] = weight_r[i*dot_pkg::num_width +: dot_pkg::num_width];
        end
    end

    // signed multiply, both operands extended to product width.
    always_comb begin
        for (int i = 0; i < dot_pkg::group_nb; i++) begin
            product[i] = dot_pkg::product_t'(data_lane[i]) *
                         dot_pkg::product_t'(weight_lane[i]);
        end
    end

    // drop the low fraction bits and keep one number width.
    always_comb begin
        for (int i = 0; i < dot_pkg::group_nb; i++) begin
            scaled[i*dot_pkg::num_width +: dot_pkg::num_width] =
                product[i][dot_pkg::fract_width +: dot_pkg::num_width];
        end
    end

    always_ff @(posedge clk) begin
        mac_data <= scaled;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mac_tag <= '0;
        end else begin
            mac_tag <= tag_r;  // stays beside mac_data.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a last strobe from upstream must always ride on a valid beat.
    last_needs_valid_a : assert property (
        @(posedge clk) disable iff (reset)
        mac_tag.last |-> mac_tag.valid
    ) else $error("group_mac: last strobe seen without valid");

endmodule

// File: common/dot_pkg.sv
package dot_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes and latencies
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int group_nb    = 4;   // lanes per beat.
    localparam int num_width   = 16;  // one number.
    localparam int fract_width = 8;   // q8.8 format.

    localparam int mac_latency = 2;   // beat to group_mac output.
    localparam int add_latency = 5;   // group_add input to output.

    localparam int group_width   = group_nb * num_width;
    localparam int product_width = 2 * num_width;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one signed fixed-point number.
    typedef logic signed [num_width-1:0] num_t;

    // lane 0 sits in the low bits.
    typedef logic [group_width-1:0] group_t;

    // full product before rescaling.
    typedef logic signed [product_width-1:0] product_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // beat and strobe bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic   valid;   // beat present this cycle.
        logic   last;    // final beat of one dot product.
        group_t data;    // activations.
        group_t weight;  // weights.
    } beat_t;

    typedef struct packed {
        logic valid;
        logic last;
    } tag_t;

    // accumulator state.
    typedef enum logic {
        acc_idle,
        acc_run
    } acc_state_t;

endpackage
